/* src/buf_pkg.sv */
package buf_pkg;

    localparam int num_ports = 4;
    localparam int page_words = 8;
    localparam int num_pages = 64;
    localparam int data_w = 16;
    localparam int max_len = 32;
    localparam int q_depth = 8;

    typedef logic [5:0] page_t;
    typedef logic [6:0] cnt_t;
    typedef logic [1:0] port_t;

    // page number in the upper bits, word within the page below
    typedef struct packed {
        page_t      page;
        logic [2:0] off;
    } word_addr_t;

endpackage

/* src/pkt_pkg.sv */
package pkt_pkg;

    typedef struct packed {
        logic [1:0]     rsvd_hi;
        logic [5:0]     len;
        logic [5:0]     rsvd_lo;
        buf_pkg::port_t dest;
    } hdr_t;

    typedef struct packed {
        buf_pkg::page_t head;
        logic [5:0]     len;
    } desc_t;

    typedef struct packed {
        buf_pkg::port_t              dest;
        logic                        sop;
        logic                        eop;
        logic [buf_pkg::data_w-1:0]  data;
    } beat_t;

    typedef struct packed {
        logic                        sop;
        logic                        eop;
        logic [buf_pkg::data_w-1:0]  data;
    } in_beat_t;

    typedef enum logic [1:0] {ing_idle, ing_data, ing_commit} ing_state_e;
    typedef enum logic [1:0] {egr_idle, egr_stream, egr_drain} egr_state_e;

    typedef enum logic [1:0] {
        cfg_port_enable  = 2'd0,
        cfg_af_threshold = 2'd1
    } cfg_reg_e;

endpackage

/* src/page_allocator.sv */
`timescale 1ns/1ps

module page_allocator (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           alloc_req,
    output buf_pkg::page_t alloc_page,
    output logic           alloc_ok,
    input  logic           rel_en,
    input  buf_pkg::page_t rel_page,
    output buf_pkg::cnt_t  free_count
);

    buf_pkg::page_t fifo [buf_pkg::num_pages];
    buf_pkg::page_t rd_ptr;
    buf_pkg::page_t wr_ptr;
    logic           take;

    assign alloc_ok = free_count != '0;
    assign alloc_page = fifo[rd_ptr];
    assign take = alloc_req && alloc_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // every page starts out free
            for (int i = 0; i < buf_pkg::num_pages; i++) begin
                fifo[i] <= buf_pkg::page_t'(i);
            end
            rd_ptr <= '0;
            wr_ptr <= '0;
            free_count <= buf_pkg::cnt_t'(buf_pkg::num_pages);
        end else begin
            if (rel_en) begin
                fifo[wr_ptr] <= rel_page;
                wr_ptr <= wr_ptr + 6'd1;
            end
            if (take) begin
                rd_ptr <= rd_ptr + 6'd1;
            end
            free_count <= free_count + buf_pkg::cnt_t'(rel_en) - buf_pkg::cnt_t'(take);
        end
    end

    a_no_alloc_empty: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_req |-> free_count != '0);

    a_no_rel_full: assert property (@(posedge clk) disable iff (!rst_n)
        rel_en |-> free_count != buf_pkg::cnt_t'(buf_pkg::num_pages));

endmodule

/* src/packet_buffer.sv */
`timescale 1ns/1ps

module packet_buffer (
    input  logic                       clk,
    input  logic                       wr_en,
    input  buf_pkg::word_addr_t        wr_addr,
    input  logic [buf_pkg::data_w-1:0] wr_data,
    input  logic                       link_en,
    input  buf_pkg::page_t             link_page,
    input  buf_pkg::page_t             link_next,
    input  logic                       rd_en,
    input  buf_pkg::word_addr_t        rd_addr,
    output logic [buf_pkg::data_w-1:0] rd_data,
    output buf_pkg::page_t             next_page
);

    logic [buf_pkg::data_w-1:0] words [buf_pkg::num_pages * buf_pkg::page_words];
    buf_pkg::page_t             jump [buf_pkg::num_pages];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            words[wr_addr] <= wr_data;
        end
        if (link_en) begin
            jump[link_page] <= link_next;
        end
        // outputs hold between reads
        if (rd_en) begin
            rd_data <= words[rd_addr];
            next_page <= jump[rd_addr.page];
        end
    end

endmodule

/* src/ingress_writer.sv */
`timescale 1ns/1ps

module ingress_writer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  pkt_pkg::in_beat_t             in_beat,
    output logic                          in_ready,
    input  logic                          alloc_ok,
    input  buf_pkg::page_t                alloc_page,
    output logic                          alloc_req,
    input  buf_pkg::cnt_t                 free_count,
    output logic                          wr_en,
    output buf_pkg::word_addr_t           wr_addr,
    output logic [buf_pkg::data_w-1:0]    wr_data,
    output logic                          link_en,
    output buf_pkg::page_t                link_page,
    output buf_pkg::page_t                link_next,
    output logic                          q_push,
    output buf_pkg::port_t                q_dest,
    output pkt_pkg::desc_t                q_desc,
    input  logic [buf_pkg::num_ports-1:0] q_full
);

    pkt_pkg::ing_state_e state;
    pkt_pkg::hdr_t       hdr;
    logic                live;
    logic                accept;
    logic                need_page;
    buf_pkg::port_t      dest;
    logic [5:0]          len;
    logic [5:0]          cnt;
    buf_pkg::page_t      head_page;
    buf_pkg::page_t      cur_page;
    buf_pkg::page_t      wpage;

    assign hdr = pkt_pkg::hdr_t'(in_beat.data);
    // first word of every page but the head page
    assign need_page = (cnt[2:0] == 3'd0) && (cnt != 6'd0);

    always_comb begin
        case (state)
            pkt_pkg::ing_idle: in_ready = live && free_count != '0 && !q_full[hdr.dest];
            pkt_pkg::ing_data: in_ready = !need_page || alloc_ok;
            default:           in_ready = 1'b0;
        endcase
    end

    assign accept = in_valid && in_ready;
    assign alloc_req = accept && (state == pkt_pkg::ing_idle || need_page);
    assign wpage = need_page ? alloc_page : cur_page;
    assign wr_en = accept && state == pkt_pkg::ing_data;
    assign wr_addr = '{page: wpage, off: cnt[2:0]};
    assign wr_data = in_beat.data;
    assign link_en = wr_en && need_page;
    assign link_page = cur_page;
    assign link_next = alloc_page;
    assign q_push = state == pkt_pkg::ing_commit;
    assign q_dest = dest;
    assign q_desc = '{head: head_page, len: len};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= pkt_pkg::ing_idle;
            live <= 1'b0;
        end else begin
            live <= 1'b1;
            case (state)
                pkt_pkg::ing_idle: if (accept) state <= pkt_pkg::ing_data;
                pkt_pkg::ing_data: if (accept && in_beat.eop) state <= pkt_pkg::ing_commit;
                default:           state <= pkt_pkg::ing_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && state == pkt_pkg::ing_idle) begin
            dest <= hdr.dest;
            len <= hdr.len;
            head_page <= alloc_page;
            cur_page <= alloc_page;
            cnt <= '0;
        end else if (wr_en) begin
            cur_page <= wpage;
            cnt <= cnt + 6'd1;
        end
    end

    a_sop_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        accept && state == pkt_pkg::ing_idle |-> in_beat.sop);

endmodule

/* src/queue_manager.sv */
`timescale 1ns/1ps

module queue_manager (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          q_push,
    input  buf_pkg::port_t                q_dest,
    input  pkt_pkg::desc_t                q_desc,
    output logic [buf_pkg::num_ports-1:0] q_full,
    input  logic                          q_pop,
    input  buf_pkg::port_t                q_sel,
    output pkt_pkg::desc_t                q_out,
    output logic [buf_pkg::num_ports-1:0] q_not_empty
);

    localparam int aw = $clog2(buf_pkg::q_depth);

    pkt_pkg::desc_t                           mem [buf_pkg::num_ports][buf_pkg::q_depth];
    logic [buf_pkg::num_ports-1:0][aw-1:0]    wr_ptr;
    logic [buf_pkg::num_ports-1:0][aw-1:0]    rd_ptr;
    logic [buf_pkg::num_ports-1:0][aw:0]      cnt;
    logic [buf_pkg::num_ports-1:0]            push_v;
    logic [buf_pkg::num_ports-1:0]            pop_v;

    always_comb begin
        for (int p = 0; p < buf_pkg::num_ports; p++) begin
            push_v[p] = q_push && q_dest == buf_pkg::port_t'(p);
            pop_v[p] = q_pop && q_sel == buf_pkg::port_t'(p);
            q_full[p] = cnt[p] == buf_pkg::q_depth;
            q_not_empty[p] = cnt[p] != '0;
        end
    end

    assign q_out = mem[q_sel][rd_ptr[q_sel]];

    always_ff @(posedge clk) begin
        if (q_push) begin
            mem[q_dest][wr_ptr[q_dest]] <= q_desc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt <= '0;
        end else begin
            for (int p = 0; p < buf_pkg::num_ports; p++) begin
                wr_ptr[p] <= wr_ptr[p] + aw'(push_v[p]);
                rd_ptr[p] <= rd_ptr[p] + aw'(pop_v[p]);
                cnt[p] <= cnt[p] + (aw + 1)'(push_v[p]) - (aw + 1)'(pop_v[p]);
            end
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        q_push |-> !q_full[q_dest]);

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        q_pop |-> q_not_empty[q_sel]);

endmodule

/* src/egress_reader.sv */
`timescale 1ns/1ps

module egress_reader (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [buf_pkg::num_ports-1:0] q_not_empty,
    input  logic [buf_pkg::num_ports-1:0] port_enable,
    output logic                          q_pop,
    output buf_pkg::port_t                q_sel,
    input  pkt_pkg::desc_t                q_out,
    output logic                          rd_en,
    output buf_pkg::word_addr_t           rd_addr,
    input  logic [buf_pkg::data_w-1:0]    rd_data,
    input  buf_pkg::page_t                next_page,
    output logic                          rel_en,
    output buf_pkg::page_t                rel_page,
    output logic                          out_valid,
    output pkt_pkg::beat_t                out_beat,
    input  logic                          out_ready
);

    pkt_pkg::egr_state_e           state;
    logic [buf_pkg::num_ports-1:0] eligible;
    buf_pkg::port_t                last_port;
    buf_pkg::port_t                pick;
    buf_pkg::port_t                dest;
    buf_pkg::page_t                page;
    logic [5:0]                    len;
    logic [5:0]                    idx;
    logic                          found;
    logic                          go;
    logic                          hop;
    logic                          last;
    logic                          capture;
    logic                          pend;
    logic                          pend_sop;
    logic                          pend_eop;

    assign eligible = q_not_empty & port_enable;

    // round robin, starting one past the last port served
    always_comb begin
        buf_pkg::port_t cand;
        pick = last_port;
        found = 1'b0;
        for (int i = 1; i <= buf_pkg::num_ports; i++) begin
            cand = last_port + buf_pkg::port_t'(i);
            if (!found && eligible[cand]) begin
                pick = cand;
                found = 1'b1;
            end
        end
    end

    assign q_pop = state == pkt_pkg::egr_idle && found;
    assign q_sel = pick;

    // pend marks a word waiting in rd_data for the output register
    assign go = !out_valid || out_ready;
    assign capture = pend && go;
    assign hop = idx[2:0] == 3'd0 && idx != 6'd0;
    assign last = idx == len - 6'd1;
    assign rd_en = state == pkt_pkg::egr_stream && go;
    assign rd_addr = '{page: hop ? next_page : page, off: idx[2:0]};
    assign rel_en = rd_en && (idx[2:0] == 3'd7 || last);
    assign rel_page = rd_addr.page;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= pkt_pkg::egr_idle;
            last_port <= '1;
            pend <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (rd_en) begin
                pend <= 1'b1;
            end else if (capture) begin
                pend <= 1'b0;
            end
            if (go) begin
                out_valid <= capture;
            end
            case (state)
                pkt_pkg::egr_idle: begin
                    if (found) begin
                        state <= pkt_pkg::egr_stream;
                        last_port <= pick;
                    end
                end
                pkt_pkg::egr_stream: if (rd_en && last) state <= pkt_pkg::egr_drain;
                default:             if (capture) state <= pkt_pkg::egr_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            dest <= pick;
            page <= q_out.head;
            len <= q_out.len;
            idx <= '0;
        end
        if (rd_en) begin
            page <= rd_addr.page;
            idx <= idx + 6'd1;
            pend_sop <= idx == 6'd0;
            pend_eop <= last;
        end
        if (capture) begin
            out_beat <= '{dest: dest, sop: pend_sop, eop: pend_eop, data: rd_data};
        end
    end

    a_hold_stall: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

/* src/port_config.sv */
`timescale 1ns/1ps

module port_config (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cfg_wr,
    input  pkt_pkg::cfg_reg_e             cfg_addr,
    input  logic [7:0]                    cfg_wdata,
    input  buf_pkg::cnt_t                 free_count,
    output logic [buf_pkg::num_ports-1:0] port_enable,
    output logic                          full,
    output logic                          almost_full
);

    buf_pkg::cnt_t af_threshold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            port_enable <= '1;
            af_threshold <= 7'd8;
            full <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            if (cfg_wr) begin
                case (cfg_addr)
                    pkt_pkg::cfg_port_enable:  port_enable <= cfg_wdata[buf_pkg::num_ports-1:0];
                    pkt_pkg::cfg_af_threshold: af_threshold <= cfg_wdata[6:0];
                    default: ;
                endcase
            end
            // flags trail free_count by one cycle
            full <= free_count == '0;
            almost_full <= free_count < af_threshold;
        end
    end

endmodule

/* src/switch_top.sv */
`timescale 1ns/1ps

module switch_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  pkt_pkg::in_beat_t in_beat,
    output logic              in_ready,
    output logic              out_valid,
    output pkt_pkg::beat_t    out_beat,
    input  logic              out_ready,
    input  logic              cfg_wr,
    input  pkt_pkg::cfg_reg_e cfg_addr,
    input  logic [7:0]        cfg_wdata,
    output logic              full,
    output logic              almost_full
);

    logic                          alloc_req;
    logic                          alloc_ok;
    buf_pkg::page_t                alloc_page;
    logic                          rel_en;
    buf_pkg::page_t                rel_page;
    buf_pkg::cnt_t                 free_count;
    logic                          wr_en;
    buf_pkg::word_addr_t           wr_addr;
    logic [buf_pkg::data_w-1:0]    wr_data;
    logic                          link_en;
    buf_pkg::page_t                link_page;
    buf_pkg::page_t                link_next;
    logic                          rd_en;
    buf_pkg::word_addr_t           rd_addr;
    logic [buf_pkg::data_w-1:0]    rd_data;
    buf_pkg::page_t                next_page;
    logic                          q_push;
    buf_pkg::port_t                q_dest;
    pkt_pkg::desc_t                q_desc;
    logic [buf_pkg::num_ports-1:0] q_full;
    logic                          q_pop;
    buf_pkg::port_t                q_sel;
    pkt_pkg::desc_t                q_out;
    logic [buf_pkg::num_ports-1:0] q_not_empty;
    logic [buf_pkg::num_ports-1:0] port_enable;

    page_allocator i_page_allocator (.*);
    packet_buffer  i_packet_buffer (.*);
    ingress_writer i_ingress_writer (.*);
    queue_manager  i_queue_manager (.*);
    egress_reader  i_egress_reader (.*);
    port_config    i_port_config (.*);

endmodule

/* dv/switch_checker.sv */
`timescale 1ns/1ps

module switch_checker (
    input logic              clk,
    input logic              rst_n,
    input logic              in_valid,
    input pkt_pkg::in_beat_t in_beat,
    input logic              in_ready,
    input logic              out_valid,
    input pkt_pkg::beat_t    out_beat,
    input logic              out_ready,
    input logic              cfg_wr,
    input pkt_pkg::cfg_reg_e cfg_addr,
    input logic [7:0]        cfg_wdata
);

    pkt_pkg::beat_t                expected [$];
    logic [buf_pkg::data_w-1:0]    words [$];
    buf_pkg::port_t                cur_dest;
    int                            cur_len;
    logic [buf_pkg::num_ports-1:0] enabled;
    int                            pending [buf_pkg::num_ports];
    int                            errors;
    int                            beats;
    string                         test_name;

    // reference model for one output beat
    function automatic pkt_pkg::beat_t expected_beat(input buf_pkg::port_t dest, input int idx,
                                                     input int len,
                                                     input logic [15:0] data [$]);
        pkt_pkg::beat_t b;
        b.dest = dest;
        b.sop = idx == 0;
        b.eop = idx == len - 1;
        b.data = data[idx];
        return b;
    endfunction

    always @(posedge clk) begin
        int            idx;
        pkt_pkg::hdr_t hdr;
        if (!rst_n) begin
            enabled = '1;
        end else begin
            if (out_valid && out_ready) begin
                // oldest beat still owed to this destination
                idx = -1;
                for (int i = expected.size() - 1; i >= 0; i--) begin
                    if (expected[i].dest == out_beat.dest) idx = i;
                end
                beats++;
                if (idx < 0) begin
                    $display("%0s: beat for port %0d with no packet pending",
                             test_name, out_beat.dest);
                    errors++;
                end else begin
                    if (out_beat !== expected[idx]) begin
                        $display("ERROR %0s: port %0d expected %h actual %h",
                                 test_name, out_beat.dest, expected[idx], out_beat);
                        errors++;
                    end
                    expected.delete(idx);
                    pending[out_beat.dest]--;
                end
                if (out_beat.sop && !enabled[out_beat.dest]) begin
                    $display("%0s: packet started on disabled port %0d", test_name, out_beat.dest);
                    errors++;
                end
            end
            if (in_valid && in_ready) begin
                if (in_beat.sop) begin
                    hdr = pkt_pkg::hdr_t'(in_beat.data);
                    cur_dest = hdr.dest;
                    cur_len = int'(hdr.len);
                    words.delete();
                end else begin
                    words.push_back(in_beat.data);
                    if (in_beat.eop) begin
                        for (int i = 0; i < words.size(); i++) begin
                            expected.push_back(expected_beat(cur_dest, i, cur_len, words));
                        end
                        pending[cur_dest] += words.size();
                    end
                end
            end
            // takes effect in the DUT on this same edge
            if (cfg_wr && cfg_addr == pkt_pkg::cfg_port_enable) begin
                enabled = cfg_wdata[buf_pkg::num_ports-1:0];
            end
        end
    end

endmodule

/* dv/switch_tb.sv */
`timescale 1ns/1ps

module switch_tb;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    pkt_pkg::in_beat_t in_beat;
    logic              in_ready;
    logic              out_valid;
    pkt_pkg::beat_t    out_beat;
    logic              out_ready;
    logic              cfg_wr;
    pkt_pkg::cfg_reg_e cfg_addr;
    logic [7:0]        cfg_wdata;
    logic              full;
    logic              almost_full;
    logic [31:0]       stim_seed;
    logic [31:0]       ready_seed;
    logic              ready_random;
    string             test_name;
    int                sent_words;
    int                tb_errors;
    int                mark;

    switch_top i_switch_top (.*);
    switch_checker i_checker (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        stim_seed = lcg(stim_seed);
        return lo + int'(stim_seed[31:8]) % (hi - lo + 1);
    endfunction

    function automatic int err_total();
        return tb_errors + i_checker.errors;
    endfunction

    function automatic int pending_sum(input logic [3:0] mask);
        int s;
        s = 0;
        for (int p = 0; p < buf_pkg::num_ports; p++) begin
            if (mask[p]) s += i_checker.pending[p];
        end
        return s;
    endfunction

    // random back pressure, three cycles in four ready
    always @(negedge clk) begin
        ready_seed = lcg(ready_seed);
        out_ready = !ready_random || ready_seed[29:28] != 2'b00;
    end

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %0s: %0s expected %b actual %b", test_name, what, exp, act);
            tb_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        i_checker.test_name = name;
        mark = err_total();
    endtask

    task automatic end_test();
        $display("test %0s: %0d errors", test_name, err_total() - mark);
        @(negedge clk);
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic push_beat(input pkt_pkg::in_beat_t b, input int max_wait, output logic ok);
        int waited;
        ok = 1'b0;
        waited = 0;
        in_valid = 1'b1;
        in_beat = b;
        while (!ok && waited < max_wait) begin
            #10;
            ok = in_ready;
            @(negedge clk);
            waited++;
        end
        in_valid = 1'b0;
    endtask

    task automatic send_packet(input int dest, input int len, input int hdr_wait,
                               output logic ok);
        pkt_pkg::hdr_t     hdr;
        pkt_pkg::in_beat_t b;
        logic              took;
        hdr = '0;
        hdr.dest = buf_pkg::port_t'(dest);
        hdr.len = 6'(len);
        b = '{sop: 1'b1, eop: 1'b0, data: hdr};
        push_beat(b, hdr_wait, ok);
        took = ok;
        for (int i = 0; i < len && took; i++) begin
            b = '{sop: 1'b0, eop: i == len - 1, data: 16'(rand_range(0, 65535))};
            push_beat(b, 400, took);
            if (!took) begin
                $display("%0s: data beat %0d for port %0d was never accepted",
                         test_name, i, dest);
                tb_errors++;
            end
        end
        if (ok) sent_words += len;
    endtask

    task automatic write_cfg(input pkt_pkg::cfg_reg_e addr, input logic [7:0] data);
        cfg_wr = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_wr = 1'b0;
    endtask

    task automatic wait_drain(input logic [3:0] mask, input int max_cycles);
        int n;
        n = 0;
        while (pending_sum(mask) != 0 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (pending_sum(mask) != 0) begin
            $display("%0s: output did not drain, %0d beats missing", test_name, pending_sum(mask));
            tb_errors++;
        end
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 2000 + 20 * sent_words) begin
            @(posedge clk);
            cycles++;
        end
        $display("watchdog: run stopped after %0d cycles", cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic ok;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_beat = '0;
        out_ready = 1'b1;
        cfg_wr = 1'b0;
        cfg_addr = pkt_pkg::cfg_port_enable;
        cfg_wdata = '0;
        stim_seed = 9147;
        ready_seed = 9147;
        ready_random = 1'b0;
        sent_words = 0;
        tb_errors = 0;

        begin_test("reset");
        repeat (16) @(negedge clk);
        check_flag("in_ready in reset", 1'b0, in_ready);
        check_flag("out_valid in reset", 1'b0, out_valid);
        check_flag("full in reset", 1'b0, full);
        check_flag("almost_full in reset", 1'b0, almost_full);
        rst_n = 1'b1;
        @(negedge clk);
        #10;
        check_flag("in_ready after reset", 1'b1, in_ready);
        check_flag("out_valid after reset", 1'b0, out_valid);
        check_flag("full after reset", 1'b0, full);
        check_flag("almost_full after reset", 1'b0, almost_full);
        end_test();

        begin_test("single_page");
        for (int p = 0; p < buf_pkg::num_ports; p++) begin
            send_packet(p, rand_range(1, 8), 400, ok);
            check_flag("header accepted", 1'b1, ok);
        end
        wait_drain(4'hf, 2000);
        end_test();

        begin_test("multi_page");
        ready_random = 1'b1;
        for (int i = 0; i < 12; i++) begin
            send_packet(rand_range(0, 3), rand_range(9, 32), 400, ok);
            check_flag("header accepted", 1'b1, ok);
        end
        wait_drain(4'hf, 4000);
        end_test();

        begin_test("port_disable");
        write_cfg(pkt_pkg::cfg_port_enable, 8'h0b);
        for (int i = 0; i < 12; i++) begin
            send_packet(i % 4, rand_range(1, 16), 400, ok);
            check_flag("header accepted", 1'b1, ok);
        end
        wait_drain(4'b1011, 3000);
        repeat (100) @(negedge clk);
        if (i_checker.pending[2] == 0) begin
            $display("%0s: port 2 packets left the switch while disabled", test_name);
            tb_errors++;
        end
        write_cfg(pkt_pkg::cfg_port_enable, 8'h0f);
        wait_drain(4'hf, 3000);
        end_test();

        begin_test("fill_drain");
        write_cfg(pkt_pkg::cfg_port_enable, 8'h00);
        // two pages per packet, so 32 packets use all 64 pages and fill every queue
        for (int i = 0; i < 32; i++) begin
            send_packet(i % 4, 16, 400, ok);
            check_flag("header accepted", 1'b1, ok);
            repeat (3) @(negedge clk);
            check_flag("almost_full while filling", 64 - 2 * (i + 1) < 8, almost_full);
            check_flag("full while filling", i == 31, full);
        end
        send_packet(0, 16, 40, ok);
        check_flag("header accepted with no free page", 1'b0, ok);
        write_cfg(pkt_pkg::cfg_port_enable, 8'h0f);
        wait_drain(4'hf, 6000);
        repeat (3) @(negedge clk);
        check_flag("almost_full after drain", 1'b0, almost_full);
        check_flag("full after drain", 1'b0, full);
        end_test();

        $display("5 tests, %0d beats checked, %0d errors", i_checker.beats, err_total());
        if (err_total() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
src/buf_pkg.sv
src/pkt_pkg.sv
src/page_allocator.sv
src/packet_buffer.sv
src/ingress_writer.sv
src/queue_manager.sv
src/egress_reader.sv
src/port_config.sv
src/switch_top.sv
dv/switch_checker.sv
dv/switch_tb.sv

/* Makefile */
TOP := switch_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
